// ==== Makefile ====
# Verilator build and run for the radio control core testbench

VERILATOR ?= verilator
TOP       ?= radio_ctrl_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/10ps

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^Simulation passed$$' $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/radio_cmd_gate.sv ====
/*
 * Command gate: accepts settings commands, holds timed ones until their
 * VITA time, drops late ones and counts them, then strobes the write
 */

`timescale 1ns/10ps

module radio_cmd_gate
  import radio_types_pkg::*;
(
  input  logic        radio_clk,
  input  logic        radio_rst,
  input  logic        cmd_valid,
  input  set_addr_t   cmd_addr,
  input  set_data_t   cmd_data,
  input  logic        cmd_has_time,
  input  vita_time_t  cmd_time,
  input  vita_time_t  vita_time,
  output logic        cmd_ready,
  output logic        wr_stb,
  output set_addr_t   wr_addr,
  output set_data_t   wr_data,
  output late_cnt_t   late_count
);

  gate_state_t state;

  // Held command
  set_addr_t  addr_q;
  set_data_t  data_q;
  logic       has_time_q;
  vita_time_t time_q;

  logic accept;

  // One command in flight, so only IDLE takes a new one
  assign cmd_ready = (state == GATE_IDLE);
  assign accept    = cmd_valid && cmd_ready;

  // Write strobe lasts exactly the one EXEC cycle
  assign wr_stb  = (state == GATE_EXEC);
  assign wr_addr = addr_q;
  assign wr_data = data_q;

  // Capture the command fields on acceptance
  always_ff @(posedge radio_clk)
  begin
    if (accept)
    begin
      addr_q     <= cmd_addr;
      data_q     <= cmd_data;
      has_time_q <= cmd_has_time;
      time_q     <= cmd_time;
    end
  end

  always_ff @(posedge radio_clk)
  begin
    if (radio_rst)
    begin
      state      <= GATE_IDLE;
      late_count <= '0;
    end
    else
    begin
      case (state)
        GATE_IDLE:
        begin
          if (accept)
            state <= GATE_CHECK;
        end
        GATE_CHECK:
        begin
          // Untimed goes straight to execute
          if (!has_time_q)
            state <= GATE_EXEC;
          else if (time_q < vita_time)
          begin
            // Already late, drop it
            state <= GATE_IDLE;
            if (late_count != '1)
              late_count <= late_count + late_cnt_t'(1);
          end
          else
            state <= GATE_WAIT;
        end
        GATE_WAIT:
        begin
          // Hold until the time counter reaches the command time
          if (vita_time >= time_q)
            state <= GATE_EXEC;
        end
        GATE_EXEC:
        begin
          state <= GATE_IDLE;
        end
        default:
        begin
          state <= GATE_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== src/radio_ctrl_core.sv ====
/*
 * Radio control core top level
 * Command gate feeds the time keeper and settings, readback returns state
 */

`timescale 1ns/10ps

module radio_ctrl_core
  import radio_types_pkg::*;
(
  input  logic       radio_clk,
  input  logic       radio_rst,
  // Command port
  input  logic       cmd_valid,
  input  set_addr_t  cmd_addr,
  input  set_data_t  cmd_data,
  input  logic       cmd_has_time,
  input  vita_time_t cmd_time,
  output logic       cmd_ready,
  // Readback request and response
  input  logic       rb_req_valid,
  input  set_addr_t  rb_addr,
  output logic       rb_req_ready,
  output logic       rb_resp_valid,
  output rb_data_t   rb_resp_data,
  input  logic       rb_resp_ready,
  // Radio side
  input  logic       pps,
  input  sample_t    rx,
  input  set_data_t  misc_ins,
  input  set_data_t  fp_gpio_in,
  output sample_t    tx,
  output set_data_t  misc_outs,
  output set_data_t  leds,
  output set_data_t  fp_gpio_out,
  output set_data_t  fp_gpio_ddr,
  output logic       sync
);

  // Internal write strobe
  logic       wr_stb;
  set_addr_t  wr_addr;
  set_data_t  wr_data;

  vita_time_t vita_time;
  late_cnt_t  late_count;
  set_data_t  test_word;
  set_data_t  loopback;

  // Decode and schedule
  radio_cmd_gate cmd_gate0 (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .cmd_valid    (cmd_valid),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .cmd_has_time (cmd_has_time),
    .cmd_time     (cmd_time),
    .vita_time    (vita_time),
    .cmd_ready    (cmd_ready),
    .wr_stb       (wr_stb),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .late_count   (late_count)
  );

  // Time base
  radio_time_keeper time_keeper0 (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .pps       (pps),
    .wr_stb    (wr_stb),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .vita_time (vita_time)
  );

  radio_settings_regs settings_regs0 (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .wr_stb      (wr_stb),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .test_word   (test_word),
    .tx          (tx),
    .loopback    (loopback),
    .misc_outs   (misc_outs),
    .leds        (leds),
    .fp_gpio_out (fp_gpio_out),
    .fp_gpio_ddr (fp_gpio_ddr),
    .sync        (sync)
  );

  // Results back to the host
  radio_readback readback0 (
    .radio_clk     (radio_clk),
    .radio_rst     (radio_rst),
    .rb_req_valid  (rb_req_valid),
    .rb_addr       (rb_addr),
    .rb_resp_ready (rb_resp_ready),
    .test_word     (test_word),
    .tx            (tx),
    .rx            (rx),
    .loopback      (loopback),
    .misc_ins      (misc_ins),
    .misc_outs     (misc_outs),
    .fp_gpio_in    (fp_gpio_in),
    .fp_gpio_out   (fp_gpio_out),
    .fp_gpio_ddr   (fp_gpio_ddr),
    .leds          (leds),
    .vita_time     (vita_time),
    .late_count    (late_count),
    .rb_req_ready  (rb_req_ready),
    .rb_resp_valid (rb_resp_valid),
    .rb_resp_data  (rb_resp_data)
  );

endmodule

// ==== src/radio_readback.sv ====
/*
 * Readback unit: selects a 64-bit word by address and holds it as a
 * response until taken, blocking new requests meanwhile
 */

`timescale 1ns/10ps

module radio_readback
  import radio_types_pkg::*;
  import radio_regmap_pkg::*;
(
  input  logic       radio_clk,
  input  logic       radio_rst,
  input  logic       rb_req_valid,
  input  set_addr_t  rb_addr,
  input  logic       rb_resp_ready,
  input  set_data_t  test_word,
  input  sample_t    tx,
  input  sample_t    rx,
  input  set_data_t  loopback,
  input  set_data_t  misc_ins,
  input  set_data_t  misc_outs,
  input  set_data_t  fp_gpio_in,
  input  set_data_t  fp_gpio_out,
  input  set_data_t  fp_gpio_ddr,
  input  set_data_t  leds,
  input  vita_time_t vita_time,
  input  late_cnt_t  late_count,
  output logic       rb_req_ready,
  output logic       rb_resp_valid,
  output rb_data_t   rb_resp_data
);

  rb_data_t  rb_word;
  sample_t   rx_sel;
  set_data_t fp_gpio_rd;
  logic      req_accept;

  // No new request while a response is pending
  assign rb_req_ready = !rb_resp_valid;
  assign req_accept   = rb_req_valid && rb_req_ready;

  // Loopback replaces the RX input with the TX sample
  assign rx_sel = loopback[0] ? tx : rx;

  // Driven pins read back their output, the rest read the pad
  assign fp_gpio_rd = (fp_gpio_out & fp_gpio_ddr) | (fp_gpio_in & ~fp_gpio_ddr);

  always_comb
  begin
    case (rb_addr)
      RB_TEST:       rb_word = rb_data_t'(test_word);
      RB_TXRX:       rb_word = {tx, rx_sel};
      RB_VITA_TIME:  rb_word = vita_time;
      RB_MISC_IO:    rb_word = {misc_ins, misc_outs};
      RB_FP_GPIO:    rb_word = rb_data_t'(fp_gpio_rd);
      RB_LEDS:       rb_word = rb_data_t'(leds);
      RB_CMD_STATUS: rb_word = rb_data_t'(late_count);
      default:       rb_word = '0;
    endcase
  end

  // Response data, held until the handshake completes
  always_ff @(posedge radio_clk)
  begin
    if (req_accept)
      rb_resp_data <= rb_word;
  end

  always_ff @(posedge radio_clk)
  begin
    if (radio_rst)
      rb_resp_valid <= 1'b0;
    else if (req_accept)
      rb_resp_valid <= 1'b1;
    else if (rb_resp_valid && rb_resp_ready)
      rb_resp_valid <= 1'b0;
  end

endmodule

// ==== src/radio_regmap_pkg.sv ====
/*
 * Radio control core register map
 * Settings and readback addresses, and the time control bit positions
 */

package radio_regmap_pkg;

  import radio_types_pkg::*;

  // Time keeper settings
  localparam set_addr_t SR_TIME_HI     = 8'd128;
  localparam set_addr_t SR_TIME_LO     = 8'd129;
  localparam set_addr_t SR_TIME_CTRL   = 8'd130;

  // Core settings
  localparam set_addr_t SR_TEST        = 8'd132;
  localparam set_addr_t SR_CODEC_IDLE  = 8'd133;
  localparam set_addr_t SR_LOOPBACK    = 8'd134;

  // Misc outputs and sync strobe
  localparam set_addr_t SR_MISC_OUTS   = 8'd160;
  localparam set_addr_t SR_SYNC        = 8'd161;

  // LEDs
  localparam set_addr_t SR_LEDS        = 8'd176;

  // Front panel GPIO, direction register sits four above the output
  localparam set_addr_t SR_FP_GPIO     = 8'd200;
  localparam set_addr_t SR_FP_GPIO_DDR = 8'd204;

  // Readback addresses
  localparam set_addr_t RB_VITA_TIME   = 8'd0;
  localparam set_addr_t RB_TEST        = 8'd2;
  localparam set_addr_t RB_TXRX        = 8'd3;
  localparam set_addr_t RB_CMD_STATUS  = 8'd5;
  localparam set_addr_t RB_MISC_IO     = 8'd16;
  localparam set_addr_t RB_LEDS        = 8'd18;
  localparam set_addr_t RB_FP_GPIO     = 8'd20;

  // Bits of the SR_TIME_CTRL data word
  // Bit 0 loads the staged time at once
  localparam int TIME_CTRL_NOW_BIT = 0;
  // Bit 1 arms a load on the next PPS rising edge
  localparam int TIME_CTRL_PPS_BIT = 1;

endpackage

// ==== src/radio_settings_regs.sv ====
/*
 * Settings register file: test word, codec idle (TX sample), loopback,
 * misc outputs, LEDs, front panel GPIO and a one-cycle sync pulse
 */

`timescale 1ns/10ps

module radio_settings_regs
  import radio_types_pkg::*;
  import radio_regmap_pkg::*;
(
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      wr_stb,
  input  set_addr_t wr_addr,
  input  set_data_t wr_data,
  output set_data_t test_word,
  output sample_t   tx,
  output set_data_t loopback,
  output set_data_t misc_outs,
  output set_data_t leds,
  output set_data_t fp_gpio_out,
  output set_data_t fp_gpio_ddr,
  output logic      sync
);

  always_ff @(posedge radio_clk)
  begin
    if (radio_rst)
    begin
      test_word   <= '0;
      tx          <= '0;
      loopback    <= '0;
      misc_outs   <= '0;
      leds        <= '0;
      fp_gpio_out <= '0;
      fp_gpio_ddr <= '0;
      sync        <= 1'b0;
    end
    else
    begin
      // Sync only lasts the cycle after its write
      sync <= 1'b0;
      if (wr_stb)
      begin
        case (wr_addr)
          SR_TEST:        test_word   <= wr_data;
          // Idle word goes out as the TX sample
          SR_CODEC_IDLE:  tx          <= sample_t'(wr_data);
          SR_LOOPBACK:    loopback    <= wr_data;
          SR_MISC_OUTS:   misc_outs   <= wr_data;
          SR_LEDS:        leds        <= wr_data;
          SR_FP_GPIO:     fp_gpio_out <= wr_data;
          SR_FP_GPIO_DDR: fp_gpio_ddr <= wr_data;
          // Data word is ignored, the write itself is the event
          SR_SYNC:        sync        <= 1'b1;
          default:
          begin
            // Other addresses belong to the time keeper or are unused
          end
        endcase
      end
    end
  end

endmodule

// ==== src/radio_time_keeper.sv ====
/*
 * VITA time keeper: free-running tick counter, loaded from staged
 * high and low words either at once or on the next PPS rising edge
 */

`timescale 1ns/10ps

module radio_time_keeper
  import radio_types_pkg::*;
  import radio_regmap_pkg::*;
(
  input  logic       radio_clk,
  input  logic       radio_rst,
  input  logic       pps,
  input  logic       wr_stb,
  input  set_addr_t  wr_addr,
  input  set_data_t  wr_data,
  output vita_time_t vita_time
);

  // Staged load value
  set_data_t time_hi;
  set_data_t time_lo;

  logic pps_q;
  logic pps_rise;
  logic pps_armed;
  logic ctrl_wr;
  logic load_now;

  assign pps_rise = pps && !pps_q;
  assign ctrl_wr  = wr_stb && (wr_addr == SR_TIME_CTRL);
  assign load_now = ctrl_wr && wr_data[TIME_CTRL_NOW_BIT];

  always_ff @(posedge radio_clk)
  begin
    if (radio_rst)
    begin
      time_hi   <= '0;
      time_lo   <= '0;
      pps_q     <= 1'b0;
      pps_armed <= 1'b0;
      vita_time <= '0;
    end
    else
    begin
      pps_q <= pps;

      // Stage the load value
      if (wr_stb && (wr_addr == SR_TIME_HI))
        time_hi <= wr_data;
      if (wr_stb && (wr_addr == SR_TIME_LO))
        time_lo <= wr_data;

      // Immediate load wins over an armed PPS load
      if (load_now)
      begin
        vita_time <= {time_hi, time_lo};
        pps_armed <= 1'b0;
      end
      else if (pps_armed && pps_rise)
      begin
        vita_time <= {time_hi, time_lo};
        pps_armed <= 1'b0;
      end
      else
      begin
        vita_time <= vita_time + vita_time_t'(1);
        // Arm for the next PPS edge
        if (ctrl_wr && wr_data[TIME_CTRL_PPS_BIT])
          pps_armed <= 1'b1;
      end
    end
  end

endmodule

// ==== src/radio_types_pkg.sv ====
/*
 * Radio control core types
 * Width typedefs for samples, settings, time and readback, and the gate FSM states
 */

package radio_types_pkg;

  // Field widths
  localparam int SAMPLE_W   = 32;
  localparam int SET_DATA_W = 32;
  localparam int SET_ADDR_W = 8;
  localparam int VITA_W     = 64;
  localparam int RB_DATA_W  = 64;
  localparam int LATE_CNT_W = 16;

  // One TX or RX sample, I in the upper half and Q in the lower half
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Settings bus data word
  typedef logic [SET_DATA_W-1:0] set_data_t;

  // Settings or readback address
  typedef logic [SET_ADDR_W-1:0] set_addr_t;

  // VITA time in radio_clk ticks
  typedef logic [VITA_W-1:0] vita_time_t;

  // Readback word
  typedef logic [RB_DATA_W-1:0] rb_data_t;

  // Saturating late command count
  typedef logic [LATE_CNT_W-1:0] late_cnt_t;

  // Command gate FSM
  typedef enum logic [1:0]
  {
    GATE_IDLE,
    GATE_CHECK,
    GATE_WAIT,
    GATE_EXEC
  } gate_state_t;

endpackage

// ==== tb.f ====
src/radio_types_pkg.sv
src/radio_regmap_pkg.sv
src/radio_cmd_gate.sv
src/radio_time_keeper.sv
src/radio_settings_regs.sv
src/radio_readback.sv
src/radio_ctrl_core.sv
tests/radio_ctrl_core_assert.sv
tests/radio_ctrl_core_tb.sv

// ==== tests/radio_ctrl_core_assert.sv ====
/*
 * Bound checks for the radio control core
 * Reset state, command and readback handshakes, sync pulse width
 */

`timescale 1ns/10ps

module radio_ctrl_core_assert
  import radio_types_pkg::*;
(
  input logic       radio_clk,
  input logic       radio_rst,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input logic       rb_resp_valid,
  input logic       rb_resp_ready,
  input rb_data_t   rb_resp_data,
  input sample_t    tx,
  input logic       sync,
  input vita_time_t vita_time,
  input late_cnt_t  late_count
);

  // Core comes out of reset idle and cleared
  reset_state: assert property (@(posedge radio_clk)
    radio_rst |=> (cmd_ready && !rb_resp_valid && !sync && (tx == '0) &&
                   (vita_time == '0) && (late_count == '0)))
    else $error("core state not cleared by reset");

  // Pending response must not move until taken
  resp_stable: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (rb_resp_valid && !rb_resp_ready) |=> (rb_resp_valid && $stable(rb_resp_data)))
    else $error("readback response changed under back-pressure");

  // Gate holds one command, ready drops right after acceptance
  cmd_held: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (cmd_valid && cmd_ready) |=> !cmd_ready)
    else $error("cmd_ready stayed high while a command was held");

  // Sync strobe lasts one cycle
  sync_width: assert property (@(posedge radio_clk) disable iff (radio_rst)
    sync |=> !sync)
    else $error("sync pulse longer than one cycle");

endmodule

bind radio_ctrl_core radio_ctrl_core_assert assert0 (
  .radio_clk     (radio_clk),
  .radio_rst     (radio_rst),
  .cmd_valid     (cmd_valid),
  .cmd_ready     (cmd_ready),
  .rb_resp_valid (rb_resp_valid),
  .rb_resp_ready (rb_resp_ready),
  .rb_resp_data  (rb_resp_data),
  .tx            (tx),
  .sync          (sync),
  .vita_time     (vita_time),
  .late_count    (late_count)
);

// ==== tests/radio_ctrl_core_tb.sv ====
/*
 * Testbench for the radio control core
 * Directed tests over settings, readback, VITA time and timed commands
 */

`timescale 1ns/10ps

module radio_ctrl_core_tb
  import radio_types_pkg::*;
  import radio_regmap_pkg::*;
();

  localparam int          CLK_PERIOD_NS   = 40;
  localparam int          RESET_CYCLES    = 16;
  localparam logic [31:0] SEED            = 32'hf2b504b9;
  // Handshake limit for one transfer
  localparam int          HS_TIMEOUT      = 64;
  localparam int          PPS_HOLD_CYCLES = 500;
  localparam int          PPS_LOAD_WINDOW = 8;
  // Cycle budget of each test
  localparam int          REG_BUDGET      = 100;
  localparam int          IDLE_BUDGET     = 150;
  localparam int          OUTS_BUDGET     = 300;
  localparam int          LATE_BUDGET     = 200;
  localparam int          PPS_BUDGET      = 1000;
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + REG_BUDGET + IDLE_BUDGET +
                                            OUTS_BUDGET + LATE_BUDGET + PPS_BUDGET;

  logic       radio_clk;
  logic       radio_rst;
  logic       cmd_valid;
  set_addr_t  cmd_addr;
  set_data_t  cmd_data;
  logic       cmd_has_time;
  vita_time_t cmd_time;
  logic       cmd_ready;
  logic       rb_req_valid;
  set_addr_t  rb_addr;
  logic       rb_req_ready;
  logic       rb_resp_valid;
  rb_data_t   rb_resp_data;
  logic       rb_resp_ready;
  logic       pps;
  sample_t    rx;
  set_data_t  misc_ins;
  set_data_t  fp_gpio_in;
  sample_t    tx;
  set_data_t  misc_outs;
  set_data_t  leds;
  set_data_t  fp_gpio_out;
  set_data_t  fp_gpio_ddr;
  logic       sync;

  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int sync_count  = 0;

  radio_ctrl_core dut0 (.*);

  initial
  begin
    radio_clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) radio_clk = ~radio_clk;
  end

  // Sync pulses, sampled away from the rising edge
  always @(negedge radio_clk)
  begin
    if (sync)
      sync_count++;
  end

  // Watchdog sized from the test budgets
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input string name, input rb_data_t got, input rb_data_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error: %s", msg);
  endtask

  task automatic report_test_result(input string name, input int errors_at_start);
    test_count++;
    $display("Test %0d %s done, %0d errors", test_count, name, error_count - errors_at_start);
  endtask

  // Per-bit direction merge, driven pins read their output
  function automatic set_data_t gpio_readback_expected(input set_data_t ddr,
                                                       input set_data_t out_val,
                                                       input set_data_t in_val);
    set_data_t merged;
    for (int i = 0; i < $bits(set_data_t); i++)
      merged[i] = ddr[i] ? out_val[i] : in_val[i];
    return merged;
  endfunction

  // Present a command, return on the falling edge after it was taken
  task automatic send_cmd(input set_addr_t addr, input set_data_t data,
                          input logic has_time, input vita_time_t when);
    int waited;
    waited = 0;
    @(negedge radio_clk);
    cmd_valid    = 1'b1;
    cmd_addr     = addr;
    cmd_data     = data;
    cmd_has_time = has_time;
    cmd_time     = when;
    while (!cmd_ready && (waited < HS_TIMEOUT))
    begin
      @(negedge radio_clk);
      waited++;
    end
    if (!cmd_ready)
      report_error("command port never became ready");
    @(negedge radio_clk);
    cmd_valid = 1'b0;
  endtask

  // Gate back in idle marks the end of the command
  task automatic wait_cmd_done(input int max_cycles);
    int waited;
    waited = 0;
    while (!cmd_ready && (waited < max_cycles))
    begin
      @(negedge radio_clk);
      waited++;
    end
    if (!cmd_ready)
      report_error("command did not complete in time");
  endtask

  task automatic write_reg(input set_addr_t addr, input set_data_t data);
    send_cmd(addr, data, 1'b0, '0);
    wait_cmd_done(HS_TIMEOUT);
  endtask

  task automatic read_rb(input set_addr_t addr, output rb_data_t data);
    int waited;
    int stall;
    waited = 0;
    stall  = $urandom_range(3, 0);
    @(negedge radio_clk);
    rb_req_valid = 1'b1;
    rb_addr      = addr;
    while (!rb_req_ready && (waited < HS_TIMEOUT))
    begin
      @(negedge radio_clk);
      waited++;
    end
    if (!rb_req_ready)
      report_error("readback request never accepted");
    @(negedge radio_clk);
    rb_req_valid = 1'b0;
    // Hold off the response for a few cycles
    repeat (stall) @(negedge radio_clk);
    waited = 0;
    while (!rb_resp_valid && (waited < HS_TIMEOUT))
    begin
      @(negedge radio_clk);
      waited++;
    end
    if (!rb_resp_valid)
      report_error("readback response never arrived");
    data          = rb_resp_data;
    rb_resp_ready = 1'b1;
    @(negedge radio_clk);
    rb_resp_ready = 1'b0;
  endtask

  task automatic test_register();
    rb_data_t rd;
    write_reg(SR_TEST, 32'hdeadbeef);
    read_rb(RB_TEST, rd);
    check_value("RB_TEST", rd, 64'h0000_0000_dead_beef);
    write_reg(SR_TEST, 32'hfeedface);
    read_rb(RB_TEST, rd);
    check_value("RB_TEST", rd, 64'h0000_0000_feed_face);
  endtask

  task automatic test_codec_idle_loopback();
    rb_data_t  rd;
    set_data_t idle;
    sample_t   rx_word;
    idle    = $urandom();
    rx_word = $urandom();
    @(negedge radio_clk);
    rx = rx_word;
    write_reg(SR_CODEC_IDLE, idle);
    check_value("tx", rb_data_t'(tx), rb_data_t'(idle));
    // Loopback puts the TX sample in both halves
    write_reg(SR_LOOPBACK, 32'd1);
    read_rb(RB_TXRX, rd);
    check_value("RB_TXRX", rd, {idle, idle});
    write_reg(SR_LOOPBACK, 32'd0);
    read_rb(RB_TXRX, rd);
    check_value("RB_TXRX", rd, {idle, rx_word});
  endtask

  task automatic test_outputs();
    rb_data_t  rd;
    set_data_t outs_word;
    set_data_t leds_word;
    set_data_t ins_word;
    set_data_t ddr_word;
    set_data_t out_word;
    set_data_t in_word;
    int        sync_before;
    outs_word = $urandom();
    leds_word = $urandom();
    ins_word  = $urandom();
    ddr_word  = $urandom();
    out_word  = $urandom();
    in_word   = $urandom();
    @(negedge radio_clk);
    misc_ins   = ins_word;
    fp_gpio_in = in_word;
    write_reg(SR_MISC_OUTS, outs_word);
    check_value("misc_outs", rb_data_t'(misc_outs), rb_data_t'(outs_word));
    write_reg(SR_LEDS, leds_word);
    check_value("leds", rb_data_t'(leds), rb_data_t'(leds_word));
    read_rb(RB_LEDS, rd);
    check_value("RB_LEDS", rd, rb_data_t'(leds_word));
    read_rb(RB_MISC_IO, rd);
    check_value("RB_MISC_IO", rd, {ins_word, outs_word});
    write_reg(SR_FP_GPIO_DDR, ddr_word);
    write_reg(SR_FP_GPIO, out_word);
    check_value("fp_gpio_ddr", rb_data_t'(fp_gpio_ddr), rb_data_t'(ddr_word));
    check_value("fp_gpio_out", rb_data_t'(fp_gpio_out), rb_data_t'(out_word));
    read_rb(RB_FP_GPIO, rd);
    check_value("RB_FP_GPIO", rd,
                rb_data_t'(gpio_readback_expected(ddr_word, out_word, in_word)));
    // One write, one pulse
    sync_before = sync_count;
    write_reg(SR_SYNC, $urandom());
    repeat (4) @(negedge radio_clk);
    check_value("sync pulse count", rb_data_t'(sync_count - sync_before), 64'd1);
  endtask

  task automatic test_late_command();
    rb_data_t  rd;
    set_data_t gpio_word;
    gpio_word = $urandom();
    write_reg(SR_TIME_HI, 32'd0);
    write_reg(SR_TIME_LO, 32'd0);
    write_reg(SR_TIME_CTRL, 32'd1 << TIME_CTRL_NOW_BIT);
    read_rb(RB_VITA_TIME, rd);
    check_count++;
    if (rd >= 64'd1000)
    begin
      error_count++;
      $display("[FAIL] RB_VITA_TIME: got 0x%h, expected below 0x%h", rd, 64'd1000);
    end
    write_reg(SR_FP_GPIO, gpio_word);
    // No late command has been sent since reset
    read_rb(RB_CMD_STATUS, rd);
    check_value("RB_CMD_STATUS", rd, 64'd0);
    // Time 1 has long gone by, so the gate drops it
    send_cmd(SR_FP_GPIO, ~gpio_word, 1'b1, 64'd1);
    wait_cmd_done(HS_TIMEOUT);
    check_value("fp_gpio_out", rb_data_t'(fp_gpio_out), rb_data_t'(gpio_word));
    read_rb(RB_CMD_STATUS, rd);
    check_value("RB_CMD_STATUS", rd, 64'd1);
  endtask

  task automatic test_pps_timed_command();
    set_data_t gpio_word;
    set_data_t next_word;
    int        ready_cycles;
    int        gpio_cycles;
    int        waited;
    gpio_word    = $urandom() | 32'h1;
    next_word    = $urandom();
    ready_cycles = 0;
    gpio_cycles  = 0;
    waited       = 0;
    write_reg(SR_FP_GPIO, 32'd0);
    write_reg(SR_TIME_HI, 32'd0);
    write_reg(SR_TIME_LO, 32'd1_000_000);
    write_reg(SR_TIME_CTRL, 32'd1 << TIME_CTRL_PPS_BIT);
    send_cmd(SR_FP_GPIO, gpio_word, 1'b1, 64'd1_000_000);
    // Command must sit in the gate until the PPS load
    for (int i = 0; i < PPS_HOLD_CYCLES; i++)
    begin
      @(negedge radio_clk);
      if (cmd_ready)
        ready_cycles++;
      if (fp_gpio_out != '0)
        gpio_cycles++;
    end
    check_value("cmd_ready high cycles before PPS", rb_data_t'(ready_cycles), 64'd0);
    check_value("fp_gpio_out set cycles before PPS", rb_data_t'(gpio_cycles), 64'd0);
    pps = 1'b1;
    while ((fp_gpio_out !== gpio_word) && (waited < PPS_LOAD_WINDOW))
    begin
      @(negedge radio_clk);
      waited++;
    end
    check_value("fp_gpio_out", rb_data_t'(fp_gpio_out), rb_data_t'(gpio_word));
    pps = 1'b0;
    wait_cmd_done(HS_TIMEOUT);
    // Untimed traffic runs as before
    write_reg(SR_FP_GPIO, next_word);
    check_value("fp_gpio_out", rb_data_t'(fp_gpio_out), rb_data_t'(next_word));
  endtask

  initial
  begin
    int errs;
    void'($urandom(SEED));
    radio_rst     = 1'b1;
    cmd_valid     = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_has_time  = 1'b0;
    cmd_time      = '0;
    rb_req_valid  = 1'b0;
    rb_addr       = '0;
    rb_resp_ready = 1'b0;
    pps           = 1'b0;
    rx            = '0;
    misc_ins      = '0;
    fp_gpio_in    = '0;
    repeat (RESET_CYCLES) @(posedge radio_clk);
    @(negedge radio_clk);
    radio_rst = 1'b0;

    errs = error_count;
    test_register();
    report_test_result("test register", errs);
    errs = error_count;
    test_codec_idle_loopback();
    report_test_result("codec idle and loopback", errs);
    errs = error_count;
    test_outputs();
    report_test_result("outputs and readbacks", errs);
    errs = error_count;
    test_late_command();
    report_test_result("late command", errs);
    errs = error_count;
    test_pps_timed_command();
    report_test_result("PPS timed command", errs);

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
